// File: spi_host_pkg.sv
package spi_host_pkg;

  // Chip selects and the width of their index
  localparam int NumCS = 2;
  localparam int CSW   = 1;

  // Command length holds the byte count minus one
  localparam int LenW = 8;
  localparam int DivW = 8;

  // Occupancy runs from 0 to FifoDepth
  localparam int FifoDepth = 8;
  localparam int DepthW    = 4;

  typedef logic [7:0] byte_t;

  typedef enum logic [1:0] {
    Standard = 2'b00,
    Dual     = 2'b01,
    Quad     = 2'b10
  } speed_e;

  typedef enum logic [1:0] {
    Dummy  = 2'b00,
    RdOnly = 2'b01,
    WrOnly = 2'b10,
    Bidir  = 2'b11
  } dir_e;

  localparam int NumErr       = 5;
  localparam int ErrBusy      = 0;
  localparam int ErrOverflow  = 1;
  localparam int ErrUnderflow = 2;
  localparam int ErrCmdInval  = 3;
  localparam int ErrCsidInval = 4;

  localparam int NumEvt     = 6;
  localparam int EvtRxFull  = 0;
  localparam int EvtTxEmpty = 1;
  localparam int EvtRxWm    = 2;
  localparam int EvtTxWm    = 3;
  localparam int EvtReady   = 4;
  localparam int EvtIdle    = 5;

  localparam int IntrErr = 0;
  localparam int IntrEvt = 1;

endpackage

// File: spi_host_if.sv
`timescale 1ns/1ns

// Status flags of one byte FIFO
interface fifo_status_if;

  logic                            empty;
  logic                            full;
  logic                            wm;
  logic [spi_host_pkg::DepthW-1:0] depth;

  modport src (output empty, full, wm, depth);
  modport snk (input empty, full, wm, depth);

endinterface

// Accepted command on its way to the shift engine
interface cmd_if;

  logic                          valid;
  logic                          ready;
  logic [spi_host_pkg::CSW-1:0]  csid;
  logic [spi_host_pkg::LenW-1:0] len;
  logic                          csaat;
  logic                          rd_en;
  logic                          wr_en;

  modport src (output valid, csid, len, csaat, rd_en, wr_en, input ready);
  modport snk (input valid, csid, len, csaat, rd_en, wr_en, output ready);

endinterface

// File: spi_host_fifo.sv
`timescale 1ns/1ns

module spi_host_fifo #(
  parameter type payload_t = spi_host_pkg::byte_t,
  // Watermark at or above the level, else at or below it
  parameter bit  WmAbove   = 1'b1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            push_i,
  input  payload_t                        data_i,
  input  logic                            pop_i,
  output payload_t                        data_o,
  input  logic [spi_host_pkg::DepthW-1:0] wm_level_i,
  output logic                            overflow_o,
  output logic                            underflow_o,
  fifo_status_if.src                      stat_o
);

  // Depth is a power of two, so the pointers wrap by themselves
  payload_t                        mem [spi_host_pkg::FifoDepth];
  logic [spi_host_pkg::DepthW-2:0] wr_ptr;
  logic [spi_host_pkg::DepthW-2:0] rd_ptr;
  logic [spi_host_pkg::DepthW-1:0] count;
  logic                            full;
  logic                            empty;
  logic                            do_push;
  logic                            do_pop;

  assign full        = (int'(count) == spi_host_pkg::FifoDepth);
  assign empty       = (count == '0);
  assign do_push     = push_i & ~full;
  assign do_pop      = pop_i & ~empty;
  assign overflow_o  = push_i & full;
  assign underflow_o = pop_i & empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push != do_pop) begin
        count <= do_push ? count + 1'b1 : count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  assign data_o       = mem[rd_ptr];
  assign stat_o.empty = empty;
  assign stat_o.full  = full;
  assign stat_o.depth = count;
  assign stat_o.wm    = WmAbove ? (count >= wm_level_i) : (count <= wm_level_i);

endmodule

// File: spi_host_cmd_check.sv
`timescale 1ns/1ns

module spi_host_cmd_check (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  logic [spi_host_pkg::CSW:0]    csid_i,
  input  logic [spi_host_pkg::LenW-1:0] len_i,
  input  spi_host_pkg::speed_e          speed_i,
  input  spi_host_pkg::dir_e            dir_i,
  input  logic                          csaat_i,
  output logic                          ready_o,
  output logic                          err_busy_o,
  output logic                          err_cmd_inval_o,
  output logic                          err_csid_inval_o,
  cmd_if.src                            cmd_o
);

  logic csid_inval;
  logic cmd_inval;
  logic accept;
  logic pend_q;

  // Only single-lane transfers exist
  assign csid_inval = (int'(csid_i) >= spi_host_pkg::NumCS);
  assign cmd_inval  = (speed_i != spi_host_pkg::Standard);

  assign err_busy_o       = cmd_valid_i & ~ready_o;
  assign err_csid_inval_o = cmd_valid_i & ready_o & csid_inval;
  assign err_cmd_inval_o  = cmd_valid_i & ready_o & cmd_inval;
  assign accept           = cmd_valid_i & ready_o & ~csid_inval & ~cmd_inval;

  // Held until the engine takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (pend_q && cmd_o.ready) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_o.csid  <= csid_i[spi_host_pkg::CSW-1:0];
      cmd_o.len   <= len_i;
      cmd_o.csaat <= csaat_i;
      cmd_o.rd_en <= (dir_i == spi_host_pkg::RdOnly) || (dir_i == spi_host_pkg::Bidir);
      cmd_o.wr_en <= (dir_i == spi_host_pkg::WrOnly) || (dir_i == spi_host_pkg::Bidir);
    end
  end

  assign cmd_o.valid = pend_q;
  assign ready_o     = ~pend_q;

endmodule

// File: spi_host_shift.sv
`timescale 1ns/1ns

module spi_host_shift (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic [spi_host_pkg::DivW-1:0]  clkdiv_i,
  cmd_if.snk                             cmd_i,
  input  spi_host_pkg::byte_t            tx_data_i,
  input  logic                           tx_empty_i,
  output logic                           tx_pop_o,
  output spi_host_pkg::byte_t            rx_data_o,
  input  logic                           rx_full_i,
  output logic                           rx_push_o,
  output logic                           sck_o,
  output logic [spi_host_pkg::NumCS-1:0] csb_o,
  output logic                           sd_o,
  input  logic                           sd_i,
  output logic                           active_o
);

  typedef enum logic [1:0] {
    Idle,
    Shift,
    Stall
  } state_e;

  state_e                         state_q;
  logic [spi_host_pkg::DivW-1:0]  div_q;
  logic [2:0]                     bit_q;
  logic [spi_host_pkg::LenW-1:0]  byte_q;
  spi_host_pkg::byte_t            sr_q;
  logic                           sck_q;
  logic [spi_host_pkg::NumCS-1:0] csb_q;
  logic                           fin_q;
  logic                           rx_pend_q;
  logic                           miso_q;
  logic [spi_host_pkg::LenW-1:0]  len_q;
  logic                           csaat_q;
  logic                           rd_q;
  logic                           wr_q;
  logic                           idle_rdy;
  logic                           take;
  logic                           half_done;
  logic                           byte_end;
  logic                           boundary;
  logic                           rx_need;
  logic                           fin;
  logic                           rx_clear;
  logic                           go_next;
  logic                           go_idle;

  assign idle_rdy    = (state_q == Idle) & en_i;
  assign cmd_i.ready = idle_rdy;
  assign take        = cmd_i.valid & idle_rdy;

  assign half_done = (state_q == Shift) && (div_q == clkdiv_i);
  assign byte_end  = half_done && sck_q && (bit_q == 3'd7);
  assign boundary  = (state_q == Stall) || byte_end;

  // In Stall the finished byte already sits in the shift register
  assign rx_need   = (state_q == Stall) ? rx_pend_q : rd_q;
  assign rx_data_o = (state_q == Stall) ? sr_q : {sr_q[6:0], miso_q};
  assign fin       = (state_q == Stall) ? fin_q : (byte_q == len_q);

  assign rx_clear  = ~rx_need | ~rx_full_i;
  assign go_next   = boundary & rx_clear & ~fin & (~wr_q | ~tx_empty_i);
  assign go_idle   = boundary & rx_clear & fin;
  assign rx_push_o = boundary & rx_need & ~rx_full_i;
  assign tx_pop_o  = go_next & wr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      div_q     <= '0;
      bit_q     <= '0;
      byte_q    <= '0;
      sr_q      <= '0;
      sck_q     <= 1'b0;
      csb_q     <= '1;
      fin_q     <= 1'b0;
      rx_pend_q <= 1'b0;
    end else begin
      if (take) begin
        state_q   <= Stall;
        byte_q    <= '0;
        fin_q     <= 1'b0;
        rx_pend_q <= 1'b0;
        for (int i = 0; i < spi_host_pkg::NumCS; i++) begin
          csb_q[i] <= (int'(cmd_i.csid) != i);
        end
      end else if (go_next) begin
        state_q <= Shift;
        sr_q    <= wr_q ? tx_data_i : '0;
        div_q   <= '0;
        bit_q   <= '0;
        sck_q   <= 1'b0;
      end else if (go_idle) begin
        state_q <= Idle;
        sck_q   <= 1'b0;
        if (!csaat_q) begin
          csb_q <= '1;
        end
      end else if (boundary) begin
        // Hold SCK low until the FIFOs let the transfer go on
        state_q   <= Stall;
        sck_q     <= 1'b0;
        sr_q      <= rx_data_o;
        fin_q     <= fin;
        rx_pend_q <= rx_need & rx_full_i;
      end else if (half_done) begin
        div_q <= '0;
        if (!sck_q) begin
          sck_q <= 1'b1;
        end else begin
          sck_q <= 1'b0;
          sr_q  <= {sr_q[6:0], miso_q};
          bit_q <= bit_q + 1'b1;
        end
      end else if (state_q == Shift) begin
        div_q <= div_q + 1'b1;
      end
      if (byte_end && !fin) begin
        byte_q <= byte_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      len_q   <= cmd_i.len;
      csaat_q <= cmd_i.csaat;
      rd_q    <= cmd_i.rd_en;
      wr_q    <= cmd_i.wr_en;
    end
    // MISO is taken on the rising SCK edge
    if (half_done && !sck_q) begin
      miso_q <= sd_i;
    end
  end

  assign sck_o    = sck_q;
  assign csb_o    = csb_q;
  assign sd_o     = sr_q[7];
  assign active_o = (state_q != Idle);

endmodule

// File: spi_host_irq.sv
`timescale 1ns/1ns

module spi_host_irq (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [spi_host_pkg::NumErr-1:0] err_i,
  input  logic [spi_host_pkg::NumErr-1:0] error_enable_i,
  input  logic [spi_host_pkg::NumErr-1:0] error_clear_i,
  output logic [spi_host_pkg::NumErr-1:0] error_status_o,
  output logic                            engine_en_o,
  fifo_status_if.snk                      tx_stat_i,
  fifo_status_if.snk                      rx_stat_i,
  input  logic                            ready_i,
  input  logic                            active_i,
  input  logic [spi_host_pkg::NumEvt-1:0] event_enable_i,
  input  logic [1:0]                      intr_enable_i,
  input  logic [1:0]                      intr_clear_i,
  output logic                            intr_error_o,
  output logic                            intr_event_o
);

  logic [spi_host_pkg::NumErr-1:0] status_q;
  logic [spi_host_pkg::NumEvt-1:0] evt_lvl;
  logic [spi_host_pkg::NumEvt-1:0] evt_q;
  logic [spi_host_pkg::NumEvt-1:0] evt_rise;
  logic [1:0]                      intr_q;
  logic                            err_hit;
  logic                            evt_hit;

  assign evt_lvl[spi_host_pkg::EvtRxFull]  = rx_stat_i.full;
  assign evt_lvl[spi_host_pkg::EvtTxEmpty] = tx_stat_i.empty;
  assign evt_lvl[spi_host_pkg::EvtRxWm]    = rx_stat_i.wm;
  assign evt_lvl[spi_host_pkg::EvtTxWm]    = tx_stat_i.wm;
  assign evt_lvl[spi_host_pkg::EvtReady]   = ready_i;
  assign evt_lvl[spi_host_pkg::EvtIdle]    = ~active_i;

  assign evt_rise = evt_lvl & ~evt_q;
  assign err_hit  = |(err_i & error_enable_i);
  assign evt_hit  = |(evt_rise & event_enable_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
      // Levels already high out of reset are not events
      evt_q    <= '1;
      intr_q   <= '0;
    end else begin
      status_q <= (status_q & ~error_clear_i) | (err_i & error_enable_i);
      evt_q    <= evt_lvl;
      intr_q[spi_host_pkg::IntrErr] <=
          (intr_q[spi_host_pkg::IntrErr] & ~intr_clear_i[spi_host_pkg::IntrErr]) | err_hit;
      intr_q[spi_host_pkg::IntrEvt] <=
          (intr_q[spi_host_pkg::IntrEvt] & ~intr_clear_i[spi_host_pkg::IntrEvt]) | evt_hit;
    end
  end

  assign error_status_o = status_q;
  assign engine_en_o    = ~|status_q;
  assign intr_error_o   = intr_q[spi_host_pkg::IntrErr] & intr_enable_i[spi_host_pkg::IntrErr];
  assign intr_event_o   = intr_q[spi_host_pkg::IntrEvt] & intr_enable_i[spi_host_pkg::IntrEvt];

endmodule

// File: spi_host.sv
`timescale 1ns/1ns

module spi_host (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            en_i,
  input  logic [spi_host_pkg::DivW-1:0]   clkdiv_i,
  input  logic                            cmd_valid_i,
  input  logic [spi_host_pkg::CSW:0]      cmd_csid_i,
  input  logic [spi_host_pkg::LenW-1:0]   cmd_len_i,
  input  spi_host_pkg::speed_e            cmd_speed_i,
  input  spi_host_pkg::dir_e              cmd_dir_i,
  input  logic                            cmd_csaat_i,
  output logic                            ready_o,
  output logic                            active_o,
  input  spi_host_pkg::byte_t             tx_data_i,
  input  logic                            tx_valid_i,
  input  logic [spi_host_pkg::DepthW-1:0] tx_wm_i,
  input  logic                            rx_ready_i,
  output spi_host_pkg::byte_t             rx_data_o,
  input  logic [spi_host_pkg::DepthW-1:0] rx_wm_i,
  output logic [spi_host_pkg::DepthW-1:0] tx_depth_o,
  output logic [spi_host_pkg::DepthW-1:0] rx_depth_o,
  input  logic [spi_host_pkg::NumErr-1:0] error_enable_i,
  input  logic [spi_host_pkg::NumErr-1:0] error_clear_i,
  output logic [spi_host_pkg::NumErr-1:0] error_status_o,
  input  logic [spi_host_pkg::NumEvt-1:0] event_enable_i,
  input  logic [1:0]                      intr_enable_i,
  input  logic [1:0]                      intr_clear_i,
  output logic                            intr_error_o,
  output logic                            intr_event_o,
  output logic                            sck_o,
  output logic [spi_host_pkg::NumCS-1:0]  csb_o,
  output logic                            sd_o,
  input  logic                            sd_i
);

  fifo_status_if tx_stat ();
  fifo_status_if rx_stat ();
  cmd_if         cmd ();

  spi_host_pkg::byte_t             tx_head;
  spi_host_pkg::byte_t             rx_byte;
  logic                            tx_pop;
  logic                            rx_push;
  logic                            engine_en;
  logic                            shift_en;
  logic [spi_host_pkg::NumErr-1:0] err;

  assign shift_en   = en_i & engine_en;
  assign tx_depth_o = tx_stat.depth;
  assign rx_depth_o = rx_stat.depth;

  spi_host_cmd_check u_cmd_check (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid_i),
    .csid_i           (cmd_csid_i),
    .len_i            (cmd_len_i),
    .speed_i          (cmd_speed_i),
    .dir_i            (cmd_dir_i),
    .csaat_i          (cmd_csaat_i),
    .ready_o          (ready_o),
    .err_busy_o       (err[spi_host_pkg::ErrBusy]),
    .err_cmd_inval_o  (err[spi_host_pkg::ErrCmdInval]),
    .err_csid_inval_o (err[spi_host_pkg::ErrCsidInval]),
    .cmd_o            (cmd)
  );

  spi_host_fifo #(
    .payload_t (spi_host_pkg::byte_t),
    .WmAbove   (1'b0)
  ) u_tx_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (tx_valid_i),
    .data_i      (tx_data_i),
    .pop_i       (tx_pop),
    .data_o      (tx_head),
    .wm_level_i  (tx_wm_i),
    .overflow_o  (err[spi_host_pkg::ErrOverflow]),
    .underflow_o (),
    .stat_o      (tx_stat)
  );

  spi_host_fifo #(
    .payload_t (spi_host_pkg::byte_t),
    .WmAbove   (1'b1)
  ) u_rx_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (rx_push),
    .data_i      (rx_byte),
    .pop_i       (rx_ready_i),
    .data_o      (rx_data_o),
    .wm_level_i  (rx_wm_i),
    .overflow_o  (),
    .underflow_o (err[spi_host_pkg::ErrUnderflow]),
    .stat_o      (rx_stat)
  );

  spi_host_shift u_shift (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (shift_en),
    .clkdiv_i   (clkdiv_i),
    .cmd_i      (cmd),
    .tx_data_i  (tx_head),
    .tx_empty_i (tx_stat.empty),
    .tx_pop_o   (tx_pop),
    .rx_data_o  (rx_byte),
    .rx_full_i  (rx_stat.full),
    .rx_push_o  (rx_push),
    .sck_o      (sck_o),
    .csb_o      (csb_o),
    .sd_o       (sd_o),
    .sd_i       (sd_i),
    .active_o   (active_o)
  );

  spi_host_irq u_irq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .err_i          (err),
    .error_enable_i (error_enable_i),
    .error_clear_i  (error_clear_i),
    .error_status_o (error_status_o),
    .engine_en_o    (engine_en),
    .tx_stat_i      (tx_stat),
    .rx_stat_i      (rx_stat),
    .ready_i        (ready_o),
    .active_i       (active_o),
    .event_enable_i (event_enable_i),
    .intr_enable_i  (intr_enable_i),
    .intr_clear_i   (intr_clear_i),
    .intr_error_o   (intr_error_o),
    .intr_event_o   (intr_event_o)
  );

endmodule

// File: spi_host_asserts.sv
`timescale 1ns/1ns

module spi_host_asserts (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic [spi_host_pkg::NumCS-1:0] csb_i,
  input logic                           sck_i,
  input logic                           active_i,
  input logic                           tx_pop_i
);

  // Chip selects are one-hot low or all high
  cs_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(~csb_i))
    else $error("more than one chip select is low");

  sck_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !active_i |-> !sck_i)
    else $error("SCK is high while the engine is idle");

  // Each byte start pops the TX FIFO once
  pop_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tx_pop_i |=> !tx_pop_i)
    else $error("TX pop lasted more than one cycle");

endmodule

bind spi_host_shift spi_host_asserts u_asserts (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .csb_i    (csb_o),
  .sck_i    (sck_o),
  .active_i (active_o),
  .tx_pop_i (tx_pop_o)
);

// File: tb_spi_host.sv
`timescale 1ns/1ns

module tb_spi_host;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            en_i;
  logic [spi_host_pkg::DivW-1:0]   clkdiv_i;
  logic                            cmd_valid_i;
  logic [spi_host_pkg::CSW:0]      cmd_csid_i;
  logic [spi_host_pkg::LenW-1:0]   cmd_len_i;
  spi_host_pkg::speed_e            cmd_speed_i;
  spi_host_pkg::dir_e              cmd_dir_i;
  logic                            cmd_csaat_i;
  logic                            ready_o;
  logic                            active_o;
  spi_host_pkg::byte_t             tx_data_i;
  logic                            tx_valid_i;
  logic [spi_host_pkg::DepthW-1:0] tx_wm_i;
  logic                            rx_ready_i;
  spi_host_pkg::byte_t             rx_data_o;
  logic [spi_host_pkg::DepthW-1:0] rx_wm_i;
  logic [spi_host_pkg::DepthW-1:0] tx_depth_o;
  logic [spi_host_pkg::DepthW-1:0] rx_depth_o;
  logic [spi_host_pkg::NumErr-1:0] error_enable_i;
  logic [spi_host_pkg::NumErr-1:0] error_clear_i;
  logic [spi_host_pkg::NumErr-1:0] error_status_o;
  logic [spi_host_pkg::NumEvt-1:0] event_enable_i;
  logic [1:0]                      intr_enable_i;
  logic [1:0]                      intr_clear_i;
  logic                            intr_error_o;
  logic                            intr_event_o;
  logic                            sck_o;
  logic [spi_host_pkg::NumCS-1:0]  csb_o;
  logic                            sd_o;
  logic                            sd_i;

  int                  fd;
  int                  checks;
  int                  errors;
  int                  last_csid;
  logic [15:0]         lfsr_q;
  spi_host_pkg::byte_t sent_q[$];

  spi_host DUT (.*);

  // MOSI looped back to MISO
  assign sd_i = sd_o;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_byte(output spi_host_pkg::byte_t b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b      = {b[6:0], lfsr_q[0]};
      lfsr_q = galois_step(lfsr_q);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic push_bytes(input int n);
    spi_host_pkg::byte_t b;
    int                  level;
    @(negedge clk_i);
    level = int'(tx_depth_o);
    for (int i = 0; i < n; i++) begin
      random_byte(b);
      // A push into a full FIFO is dropped
      if (level < spi_host_pkg::FifoDepth) begin
        sent_q.push_back(b);
        level++;
      end
      @(posedge clk_i);
      tx_valid_i <= 1'b1;
      tx_data_i  <= b;
    end
    @(posedge clk_i);
    tx_valid_i <= 1'b0;
  endtask

  task automatic send_cmd(input int csid, input int len, input int speed, input int dir,
                          input int csaat);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_csid_i  <= csid[spi_host_pkg::CSW:0];
    cmd_len_i   <= len[spi_host_pkg::LenW-1:0];
    cmd_speed_i <= spi_host_pkg::speed_e'(speed[1:0]);
    cmd_dir_i   <= spi_host_pkg::dir_e'(dir[1:0]);
    cmd_csaat_i <= csaat[0];
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    if (csid < spi_host_pkg::NumCS) begin
      last_csid = csid;
    end
  endtask

  // Only the chip select of the last command may go low meanwhile
  task automatic wait_idle();
    int                             n;
    logic [spi_host_pkg::NumCS-1:0] sel;
    n   = 0;
    sel = {{(spi_host_pkg::NumCS-1){1'b0}}, 1'b1} << last_csid;
    @(negedge clk_i);
    while (!(ready_o && !active_o) && n < 5000) begin
      checks++;
      assert ((csb_o | sel) == '1) else begin
        errors++;
        $display("Error: csb_o is %h while only csb %0d may be low", csb_o, last_csid);
      end
      @(negedge clk_i);
      n++;
    end
    if (n >= 5000) begin
      report_failure("Timed out waiting for the engine to return to idle");
    end
  endtask

  task automatic hold_quiet(input int n, input int rdy);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      check_value("active_o", 32'(active_o), 0);
      check_value("csb_o", 32'(csb_o), 32'({spi_host_pkg::NumCS{1'b1}}));
      check_value("ready_o", 32'(ready_o), rdy);
    end
  endtask

  // Mode 0 expects pushed bytes, 1 expects zero bytes, 2 pops unchecked
  task automatic pop_bytes(input int n, input int mode);
    spi_host_pkg::byte_t exp;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      if (mode != 2 && rx_depth_o == '0) begin
        report_failure("RX FIFO was empty where a received byte was expected");
      end else if (mode == 1) begin
        check_value("rx_data_o", 32'(rx_data_o), 0);
      end else if (mode == 0) begin
        if (sent_q.size() == 0) begin
          report_failure("No pushed byte is left to compare with the RX data");
        end else begin
          exp = sent_q.pop_front();
          check_value("rx_data_o", 32'(rx_data_o), 32'(exp));
        end
      end
      @(posedge clk_i);
      rx_ready_i <= 1'b1;
      @(posedge clk_i);
      rx_ready_i <= 1'b0;
    end
  endtask

  task automatic run_line(input logic [63:0] op, output bit stop);
    int               code;
    int               a;
    int               b;
    int               c;
    int               d;
    int               e;
    logic [8*160-1:0] rest;
    stop = 1'b0;
    case (op)
      64'("#"): code = $fgets(rest, fd);
      64'("enable"): begin
        code = $fscanf(fd, "%h %h %h", a, b, c);
        @(posedge clk_i);
        error_enable_i <= a[spi_host_pkg::NumErr-1:0];
        event_enable_i <= b[spi_host_pkg::NumEvt-1:0];
        intr_enable_i  <= c[1:0];
      end
      64'("push"): begin
        code = $fscanf(fd, "%d", a);
        push_bytes(a);
      end
      64'("cmd"): begin
        code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
        send_cmd(a, b, c, d, e);
      end
      64'("idle"): wait_idle();
      64'("quiet"): begin
        code = $fscanf(fd, "%d %d", a, b);
        hold_quiet(a, b);
      end
      64'("pop"): begin
        code = $fscanf(fd, "%d %d", a, b);
        pop_bytes(a, b);
      end
      64'("status"): begin
        code = $fscanf(fd, "%h", a);
        @(negedge clk_i);
        check_value("error_status_o", 32'(error_status_o), a);
      end
      64'("depth"): begin
        code = $fscanf(fd, "%d", a);
        @(negedge clk_i);
        check_value("tx_depth_o", 32'(tx_depth_o), a);
      end
      64'("intr"): begin
        code = $fscanf(fd, "%d %d", a, b);
        @(negedge clk_i);
        check_value("intr_error_o", 32'(intr_error_o), a);
        check_value("intr_event_o", 32'(intr_event_o), b);
      end
      64'("clear"): begin
        code = $fscanf(fd, "%h %h", a, b);
        @(posedge clk_i);
        error_clear_i <= a[spi_host_pkg::NumErr-1:0];
        intr_clear_i  <= b[1:0];
        @(posedge clk_i);
        error_clear_i <= '0;
        intr_clear_i  <= '0;
      end
      default: begin
        report_failure("Unknown operation in the stimulus file");
        stop = 1'b1;
      end
    endcase
  endtask

  initial begin
    logic [63:0] op;
    int          code;
    bit          done;
    checks         = 0;
    errors         = 0;
    last_csid      = 0;
    lfsr_q         = 16'd31;
    rst_ni         = 1'b0;
    en_i           = 1'b1;
    clkdiv_i       = 8'd1;
    cmd_valid_i    = 1'b0;
    cmd_csid_i     = '0;
    cmd_len_i      = '0;
    cmd_speed_i    = spi_host_pkg::Standard;
    cmd_dir_i      = spi_host_pkg::Dummy;
    cmd_csaat_i    = 1'b0;
    tx_data_i      = '0;
    tx_valid_i     = 1'b0;
    tx_wm_i        = 4'd2;
    rx_ready_i     = 1'b0;
    rx_wm_i        = 4'd6;
    error_enable_i = '0;
    error_clear_i  = '0;
    event_enable_i = '0;
    intr_enable_i  = '0;
    intr_clear_i   = '0;
    done           = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen("spi_host_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the stimulus file");
    end else begin
      while (!done) begin
        code = $fscanf(fd, "%s", op);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          run_line(op, done);
        end
      end
      $fclose(fd);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: spi_host_stimulus.txt
# ops: enable err evt intr (hex) | push n | cmd csid len speed dir csaat | idle
# quiet cycles ready | pop n mode (0 pushed, 1 zero, 2 none) | status hex | depth n | intr err evt | clear err intr (hex)
enable 1f 00 3
push 4
cmd 1 3 0 3 0
idle
pop 4 0
status 00
intr 0 0
cmd 2 0 0 3 0
status 10
intr 1 0
quiet 10 1
clear 1f 3
intr 0 0
cmd 0 0 1 3 0
status 08
cmd 0 0 0 1 0
quiet 20 0
clear 1f 3
idle
pop 1 1
status 00
cmd 0 3 0 1 0
cmd 0 3 0 1 0
cmd 0 3 0 1 0
status 01
clear 1f 3
idle
pop 8 1
push 9
status 02
depth 8
clear 1f 3
cmd 0 7 0 3 0
idle
pop 8 0
pop 1 2
status 04
clear 1f 3
enable 1f 20 3
intr 0 0
push 2
cmd 1 1 0 3 0
idle
intr 0 1
clear 00 2
intr 0 0
pop 2 0
enable 1f 00 3
push 1
cmd 0 0 0 3 0
idle
intr 0 0
pop 1 0
status 00

// File: sim.f
spi_host_pkg.sv
spi_host_if.sv
spi_host_fifo.sv
spi_host_cmd_check.sv
spi_host_shift.sv
spi_host_irq.sv
spi_host.sv
spi_host_asserts.sv
tb_spi_host.sv

// File: run.sh
#!/bin/sh
# Build and run the SPI host testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_spi_host -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
